//--- lsu_pkg.sv
// shared types and widths for the load/store unit
package lsu_pkg;

  // data and address width
  localparam int xlen = 32;

  // rv32i memory operations, 3-bit encoding
  typedef enum logic [2:0] {
    op_lb,   // byte, sign extended
    op_lh,   // halfword, sign extended
    op_lw,   // word
    op_lbu,  // byte, zero extended
    op_lhu,  // halfword, zero extended
    op_sb,
    op_sh,
    op_sw
  } mem_op_e;

endpackage

//--- stage_handshake.sv
`timescale 1ns/1ps

module stage_handshake (
  input  logic clk,
  input  logic reset,
  input  logic input_valid,
  input  logic output_ready,
  input  logic busy,
  output logic unit_ready,
  output logic unit_valid
);

  logic pending;  // stage owns an item, finished or still working on it
  logic accept;

  assign accept = input_valid && unit_ready;

  // item is presented only once the stage stops working on it
  assign unit_valid = pending && !busy;

  // room for a new item when idle and the output slot is free or draining
  assign unit_ready = !busy && (!unit_valid || output_ready);

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (accept) begin
      pending <= 1'b1;  // also covers accept and hand-off on the same edge
    end else if (unit_valid && output_ready) begin
      pending <= 1'b0;
    end
  end

endmodule

//--- address_stage.sv
`timescale 1ns/1ps

module address_stage import lsu_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            in_valid,
  output logic            in_ready,
  input  mem_op_e         in_op,
  input  logic [xlen-1:0] in_base,
  input  logic [xlen-1:0] in_offset,
  input  logic [xlen-1:0] in_wdata,
  input  logic [4:0]      in_rd,
  output logic            out_valid,
  input  logic            out_ready,
  output mem_op_e         out_op,
  output logic [xlen-1:0] out_ea,
  output logic [xlen-1:0] out_wdata,
  output logic [4:0]      out_rd
);

  logic accept;

  // single cycle stage, never busy
  stage_handshake handshake_inst (
    .clk          (clk),
    .reset        (reset),
    .input_valid  (in_valid),
    .output_ready (out_ready),
    .busy         (1'b0),
    .unit_ready   (in_ready),
    .unit_valid   (out_valid)
  );

  assign accept = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (accept) begin
      out_op    <= in_op;
      out_ea    <= in_base + in_offset;  // wraps modulo 2^32
      out_wdata <= in_wdata;
      out_rd    <= in_rd;
    end
  end

endmodule

//--- accessor.sv
`timescale 1ns/1ps

module accessor import lsu_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            in_valid,
  output logic            in_ready,
  input  mem_op_e         in_op,
  input  logic [xlen-1:0] in_ea,
  input  logic [xlen-1:0] in_wdata,
  input  logic [4:0]      in_rd,
  output logic            mem_req,
  input  logic            mem_ack,
  output logic [xlen-1:0] mem_addr,
  output logic [xlen-1:0] mem_wdata,
  output logic [3:0]      mem_wstrb,
  input  logic [xlen-1:0] mem_rdata,
  output logic            out_valid,
  input  logic            out_ready,
  output mem_op_e         out_op,
  output logic [4:0]      out_rd,
  output logic [xlen-1:0] out_data
);

  typedef enum logic [1:0] {
    idle,
    load,
    store
  } state_e;

  state_e          state;
  logic            busy;
  logic            accept;
  logic            is_store;
  logic [1:0]      byte_off;    // low address bits of the pending access
  logic [3:0]      store_strb;
  logic [xlen-1:0] store_data;
  logic [xlen-1:0] byte_sel;
  logic [xlen-1:0] half_sel;
  logic [xlen-1:0] load_data;

  assign busy = (state != idle);  // memory request in flight

  stage_handshake handshake_inst (
    .clk          (clk),
    .reset        (reset),
    .input_valid  (in_valid),
    .output_ready (out_ready),
    .busy         (busy),
    .unit_ready   (in_ready),
    .unit_valid   (out_valid)
  );

  assign accept   = in_valid && in_ready;
  assign is_store = in_op inside {op_sb, op_sh, op_sw};

  // strobes and replicated write data, loads leave strobes at zero
  always_comb begin
    store_strb = 4'b0000;
    store_data = in_wdata;
    case (in_op)
      op_sb: begin
        store_strb = 4'b0001 << in_ea[1:0];
        store_data = {(xlen / 8){in_wdata[7:0]}};
      end
      op_sh: begin
        store_strb = in_ea[1] ? 4'b1100 : 4'b0011;  // bit 0 ignored
        store_data = {(xlen / 16){in_wdata[15:0]}};
      end
      op_sw: store_strb = 4'b1111;
      default: ;
    endcase
  end

  // move the addressed byte or halfword down to bit 0
  assign byte_sel = mem_rdata >> {byte_off, 3'b000};
  assign half_sel = mem_rdata >> {byte_off[1], 4'b0000};

  always_comb begin
    case (out_op)
      op_lb:   load_data = {{(xlen - 8){byte_sel[7]}}, byte_sel[7:0]};
      op_lbu:  load_data = {{(xlen - 8){1'b0}}, byte_sel[7:0]};
      op_lh:   load_data = {{(xlen - 16){half_sel[15]}}, half_sel[15:0]};
      op_lhu:  load_data = {{(xlen - 16){1'b0}}, half_sel[15:0]};
      default: load_data = mem_rdata;  // lw
    endcase
  end

  // control
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      mem_req   <= 1'b0;
      mem_wstrb <= 4'b0000;
    end else begin
      case (state)
        idle: begin
          if (accept) begin
            mem_req   <= 1'b1;  // request starts next cycle
            mem_wstrb <= store_strb;
            state     <= is_store ? store : load;
          end
        end
        load, store: begin
          if (mem_ack) begin
            mem_req   <= 1'b0;
            mem_wstrb <= 4'b0000;
            state     <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // request payload and result
  always_ff @(posedge clk) begin
    if (accept) begin
      out_op    <= in_op;
      out_rd    <= in_rd;
      byte_off  <= in_ea[1:0];
      mem_addr  <= {in_ea[xlen-1:2], 2'b00};  // always word aligned
      mem_wdata <= store_data;
    end
    if (mem_ack && state == load) begin
      out_data <= load_data;
    end
  end

endmodule

//--- writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage import lsu_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            in_valid,
  output logic            in_ready,
  input  mem_op_e         in_op,
  input  logic [4:0]      in_rd,
  input  logic [xlen-1:0] in_data,
  output logic            commit_valid,
  input  logic            commit_ready,
  output logic [4:0]      commit_rd,
  output logic [xlen-1:0] commit_data,
  input  logic [4:0]      rf_raddr,
  output logic [xlen-1:0] rf_rdata
);

  logic [xlen-1:0] regs [32];
  logic            is_load;
  logic            take_load;

  assign is_load = in_op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};

  // stores pass the handshake as accepted but never become a commit
  stage_handshake handshake_inst (
    .clk          (clk),
    .reset        (reset),
    .input_valid  (in_valid && is_load),
    .output_ready (commit_ready),
    .busy         (1'b0),
    .unit_ready   (in_ready),
    .unit_valid   (commit_valid)
  );

  assign take_load = in_valid && in_ready && is_load;

  always_ff @(posedge clk) begin
    if (take_load) begin
      commit_rd   <= in_rd;
      commit_data <= in_data;
    end
  end

  // register file, x0 never written
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (commit_valid && commit_ready && commit_rd != 5'd0) begin
      regs[commit_rd] <= commit_data;
    end
  end

  assign rf_rdata = regs[rf_raddr];

endmodule

//--- data_memory.sv
`timescale 1ns/1ps

module data_memory import lsu_pkg::*; #(
  parameter int mem_words   = 256,
  parameter int mem_latency = 2
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            mem_req,
  output logic            mem_ack,
  input  logic [xlen-1:0] mem_addr,
  input  logic [xlen-1:0] mem_wdata,
  input  logic [3:0]      mem_wstrb,
  output logic [xlen-1:0] mem_rdata
);

  localparam int aw = $clog2(mem_words);
  localparam int cw = $clog2(mem_latency + 1);

  logic [xlen-1:0] mem [mem_words];
  logic [aw-1:0]   widx;   // upper address bits dropped
  logic [cw-1:0]   count;  // cycles spent on the current request
  logic            done;

  assign widx = mem_addr[aw+1:2];

  // the ack cycle still sees mem_req high, so it must not restart the count
  assign done = mem_req && !mem_ack && (count == cw'(mem_latency - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      count   <= '0;
      mem_ack <= 1'b0;
    end else begin
      mem_ack <= done;  // one cycle pulse
      if (done) begin
        count <= '0;
      end else if (mem_req && !mem_ack) begin
        count <= count + 1'b1;
      end
    end
  end

  // byte-strobed word storage
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < mem_words; i++) begin
        mem[i] <= '0;
      end
    end else if (done) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_wstrb[b]) begin
          mem[widx][8*b +: 8] <= mem_wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (done && mem_wstrb == 4'b0000) begin
      mem_rdata <= mem[widx];
    end
  end

endmodule

//--- lsu_top.sv
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; #(
  parameter int mem_words   = 256,
  parameter int mem_latency = 2
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            req_valid,
  output logic            req_ready,
  input  mem_op_e         req_op,
  input  logic [xlen-1:0] req_base,
  input  logic [xlen-1:0] req_offset,
  input  logic [xlen-1:0] req_wdata,
  input  logic [4:0]      req_rd,
  output logic            commit_valid,
  input  logic            commit_ready,
  output logic [4:0]      commit_rd,
  output logic [xlen-1:0] commit_data,
  input  logic [4:0]      rf_raddr,
  output logic [xlen-1:0] rf_rdata
);

  // address stage to accessor
  logic            addr_valid;
  logic            accessor_ready;
  mem_op_e         addr_op;
  logic [xlen-1:0] addr_ea;
  logic [xlen-1:0] addr_wdata;
  logic [4:0]      addr_rd;

  // accessor to writeback
  logic            acc_valid;
  logic            wb_ready;
  mem_op_e         acc_op;
  logic [4:0]      acc_rd;
  logic [xlen-1:0] acc_data;

  // memory bus
  logic            mem_req;
  logic            mem_ack;
  logic [xlen-1:0] mem_addr;
  logic [xlen-1:0] mem_wdata;
  logic [3:0]      mem_wstrb;
  logic [xlen-1:0] mem_rdata;

  address_stage address_stage_inst (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (req_valid),
    .in_ready  (req_ready),
    .in_op     (req_op),
    .in_base   (req_base),
    .in_offset (req_offset),
    .in_wdata  (req_wdata),
    .in_rd     (req_rd),
    .out_valid (addr_valid),
    .out_ready (accessor_ready),
    .out_op    (addr_op),
    .out_ea    (addr_ea),
    .out_wdata (addr_wdata),
    .out_rd    (addr_rd)
  );

  accessor accessor_inst (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (addr_valid),
    .in_ready  (accessor_ready),
    .in_op     (addr_op),
    .in_ea     (addr_ea),
    .in_wdata  (addr_wdata),
    .in_rd     (addr_rd),
    .mem_req   (mem_req),
    .mem_ack   (mem_ack),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .out_valid (acc_valid),
    .out_ready (wb_ready),
    .out_op    (acc_op),
    .out_rd    (acc_rd),
    .out_data  (acc_data)
  );

  writeback_stage writeback_stage_inst (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (acc_valid),
    .in_ready     (wb_ready),
    .in_op        (acc_op),
    .in_rd        (acc_rd),
    .in_data      (acc_data),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data),
    .rf_raddr     (rf_raddr),
    .rf_rdata     (rf_rdata)
  );

  data_memory #(
    .mem_words   (mem_words),
    .mem_latency (mem_latency)
  ) data_memory_inst (
    .clk       (clk),
    .reset     (reset),
    .mem_req   (mem_req),
    .mem_ack   (mem_ack),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata)
  );

endmodule

//--- tb_lsu_assert.sv
`timescale 1ns/1ps

module tb_lsu_assert import lsu_pkg::*; (
  input logic            clk,
  input logic            reset,
  input logic            mem_req,
  input logic            mem_ack,
  input logic [xlen-1:0] mem_addr,
  input logic [xlen-1:0] mem_wdata,
  input logic [3:0]      mem_wstrb,
  input logic            out_valid,
  input logic            out_ready,
  input logic [xlen-1:0] out_data
);

  // request level and payload held until the acknowledge
  assert property (@(posedge clk) disable iff (reset)
    mem_req && !mem_ack |=> mem_req && $stable(mem_addr) && $stable(mem_wstrb)
      && $stable(mem_wdata))
    else $error("mem_req dropped or its payload changed before mem_ack");

  // stalled result keeps its data
  assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else $error("accessor result changed or vanished while stalled");

endmodule

bind accessor tb_lsu_assert protocol_check (
  .clk       (clk),
  .reset     (reset),
  .mem_req   (mem_req),
  .mem_ack   (mem_ack),
  .mem_addr  (mem_addr),
  .mem_wdata (mem_wdata),
  .mem_wstrb (mem_wstrb),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_data  (out_data)
);

//--- tb_lsu_top.sv
`timescale 1ns/1ps

module tb_lsu_top import lsu_pkg::*; ();

  localparam int mem_words   = 256;
  localparam int mem_latency = 2;
  localparam int clk_period  = 100;
  localparam int max_lines   = 64;
  localparam int cols        = 6;  // op base offset wdata rd expected

  typedef struct packed {
    logic [4:0]      rd;
    logic [xlen-1:0] data;
  } commit_t;

  logic            clk;
  logic            reset;
  logic            req_valid;
  logic            req_ready;
  mem_op_e         req_op;
  logic [xlen-1:0] req_base;
  logic [xlen-1:0] req_offset;
  logic [xlen-1:0] req_wdata;
  logic [4:0]      req_rd;
  logic            commit_valid;
  logic            commit_ready;
  logic [4:0]      commit_rd;
  logic [xlen-1:0] commit_data;
  logic [4:0]      rf_raddr;
  logic [xlen-1:0] rf_rdata;

  logic [31:0]     testdata [max_lines * cols];
  int              num_lines;
  bit              data_ready;
  commit_t         expected_q [$];  // load commits still to come, in order
  logic [xlen-1:0] expected_regs [32];
  bit              reg_used [32];

  lsu_top #(
    .mem_words   (mem_words),
    .mem_latency (mem_latency)
  ) lsu_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic stop_on_failure();
    $display("Something failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic load_testdata();
    for (int i = 0; i < max_lines * cols; i++) begin
      testdata[i] = 32'hffff_ffff;  // end marker, no op has this code
    end
    $readmemh("lsu_testdata.txt", testdata);
    num_lines = 0;
    while (num_lines < max_lines && testdata[num_lines * cols] != 32'hffff_ffff) begin
      num_lines++;
    end
    assert (num_lines > 0) else begin
      $display("test data file is missing or holds no request lines");
      stop_on_failure();
    end
    data_ready = 1'b1;
  endtask

  // loads get a commit entry and update the register model
  task automatic queue_expected(input int idx);
    commit_t item;
    item.rd   = testdata[idx * cols + 4][4:0];
    item.data = testdata[idx * cols + 5];
    if (testdata[idx * cols][2:0] < 3'd5) begin
      expected_q.push_back(item);
      if (item.rd != 5'd0) begin
        expected_regs[item.rd] = item.data;
        reg_used[item.rd]      = 1'b1;
      end
    end
  endtask

  task automatic send_request(input int idx);
    logic taken;
    taken      = 1'b0;
    req_valid  = 1'b1;
    req_op     = mem_op_e'(testdata[idx * cols][2:0]);
    req_base   = testdata[idx * cols + 1];
    req_offset = testdata[idx * cols + 2];
    req_wdata  = testdata[idx * cols + 3];
    req_rd     = testdata[idx * cols + 4][4:0];
    while (!taken) begin
      #(clk_period / 4);  // commit_ready moved on this falling edge
      taken = req_ready;
      @(negedge clk);
    end
    req_valid = 1'b0;
  endtask

  task automatic check_commit();
    commit_t want;
    assert (expected_q.size() != 0) else begin
      $display("a commit for x%0d arrived with no load outstanding", commit_rd);
      stop_on_failure();
    end
    want = expected_q.pop_front();
    assert (commit_rd == want.rd) else begin
      $display("** Error: commit_rd = 0x%02h, expected 0x%02h", commit_rd, want.rd);
      stop_on_failure();
    end
    assert (commit_data == want.data) else begin
      $display("** Error: commit_data = 0x%08h, expected 0x%08h", commit_data, want.data);
      stop_on_failure();
    end
  endtask

  task automatic drain_pipeline();
    while (expected_q.size() != 0) @(negedge clk);
    repeat (mem_latency + 10) @(negedge clk);  // last write lands, late extras show up
    assert (commit_valid == 1'b0) else begin
      $display("an extra commit appeared after every load was committed");
      stop_on_failure();
    end
  endtask

  task automatic check_registers();
    for (int r = 0; r < 32; r++) begin
      if (r == 0 || reg_used[r]) begin
        rf_raddr = 5'(r);
        @(negedge clk);
        assert (rf_rdata == expected_regs[r]) else begin
          $display("** Error: rf_rdata at x%0d = 0x%08h, expected 0x%08h",
                   r, rf_rdata, expected_regs[r]);
          stop_on_failure();
        end
      end
    end
  endtask

  // random back-pressure, a commit is checked on the cycle it will be taken
  always @(negedge clk) begin
    if (!reset) begin
      commit_ready = ($urandom % 4) != 0;
      if (commit_valid && commit_ready) begin
        check_commit();
      end
    end
  end

  initial begin
    int limit;
    wait (data_ready);
    limit = num_lines * (mem_latency + 10) + 50;
    repeat (limit) @(posedge clk);
    $display("timeout, the run did not finish within %0d cycles", limit);
    stop_on_failure();
  end

  initial begin
    void'($urandom(61105));
    reset        = 1'b1;
    req_valid    = 1'b0;
    req_op       = op_lb;
    req_base     = '0;
    req_offset   = '0;
    req_wdata    = '0;
    req_rd       = '0;
    commit_ready = 1'b0;
    rf_raddr     = '0;
    for (int r = 0; r < 32; r++) begin
      expected_regs[r] = '0;
      reg_used[r]      = 1'b0;
    end
    load_testdata();
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < num_lines; i++) begin
      queue_expected(i);
      send_request(i);
      repeat ($urandom % 4) @(negedge clk);  // idle gap
    end
    drain_pipeline();
    check_registers();
    $display("Everything OK");
    $finish;
  end

endmodule

//--- lsu_top.f
lsu_pkg.sv
stage_handshake.sv
address_stage.sv
accessor.sv
writeback_stage.sv
data_memory.sv
lsu_top.sv
tb_lsu_assert.sv
tb_lsu_top.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu_top \
  -f lsu_top.f -o tb_lsu_top \
  && ./obj_dir/tb_lsu_top \
  || { echo "simulation did not pass"; exit 1; }

//--- lsu_testdata.txt
// columns: op base offset wdata rd expected, all hex; expected is 0 for stores
// ops: 0 lb 1 lh 2 lw 3 lbu 4 lhu 5 sb 6 sh 7 sw
5 00000100 00000000 00000085 00 00000000
5 00000100 00000001 1234567f 00 00000000
5 00000104 fffffffe ffffffa0 00 00000000
5 000000f0 00000013 0000003c 00 00000000
0 00000100 00000000 00000000 01 ffffff85
0 00000101 00000000 00000000 02 0000007f
0 00000110 fffffff2 00000000 03 ffffffa0
0 00000000 00000103 00000000 04 0000003c
3 00000100 00000000 00000000 05 00000085
3 00000100 00000001 00000000 06 0000007f
3 00000100 00000002 00000000 07 000000a0
3 00000104 ffffffff 00000000 08 0000003c
2 00000100 00000000 00000000 09 3ca07f85
6 00000200 00000000 dead8001 00 00000000
6 00000200 00000002 00007ffe 00 00000000
6 00000204 00000000 00001234 00 00000000
6 00000208 fffffffe 5555c0de 00 00000000
1 00000200 00000000 00000000 0a ffff8001
1 00000202 00000000 00000000 0b 00007ffe
1 00000204 00000000 00000000 0c 00001234
1 00000200 00000006 00000000 0d ffffc0de
4 00000200 00000000 00000000 0e 00008001
4 00000200 00000002 00000000 0f 00007ffe
4 00000206 00000000 00000000 10 0000c0de
2 00000200 00000000 00000000 11 7ffe8001
2 00000208 fffffffc 00000000 12 c0de1234
7 00000310 fffffff0 89abcdef 00 00000000
2 00000320 ffffffe0 00000000 13 89abcdef
7 00000400 fffffffc 01020304 00 00000000
2 000003f0 0000000c 00000000 01 01020304
0 000003ff 00000000 00000000 14 00000001
3 00000400 fffffffd 00000000 15 00000003
2 00000300 00000000 00000000 00 89abcdef
